/* dv/execStageTb.sv */
`timescale 1ns/100ps

module execStageTb;
	import pipePkg::*;

	logic        clk;
	logic        arstN;
	logic        flush;
	idExBundle_t decodeIn;
	logic        stall;
	retire_t     retireOut;

	idExBundle_t seenIn; // Upstream values as seen before each edge
	logic        seenFlush;
	logic        sawStall;
	string       curName;
	string       seenName;
	retire_t     expRet; // Expected record of the instruction in ID/EX
	string       expName;
	logic        expStore;
	memAddr_t    expAddr;
	word_t       expData;
	int          expStallLen;
	int          stallCnt;
	word_t       shadow [MEM_WORDS];
	int          mismatchErrors = 0;
	int          otherErrors = 0;
	idExBundle_t ins;
	idExBundle_t storeIns;

	execStage i_execStage (
		.clk       (clk),
		.arstN     (arstN),
		.flush     (flush),
		.decodeIn  (decodeIn),
		.stall     (stall),
		.retireOut (retireOut)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic word_t aluRef(input aluCtrl_t code, input word_t a, input word_t b);
		logic [WORD_WIDTH:0] wide;
		int                  s;
		word_t               r;
		s    = int'(b[3:0]);
		wide = {1'b0, a} + {1'b0, b};
		r    = '0;
		case (code)
			4'd0:  r = wide[WORD_WIDTH-1:0];
			4'd1:  r = a - b;
			4'd2:  r = a ^ b;
			4'd3:  r = a & ~b;
			4'd4:  r = (a << s) | (a >> (WORD_WIDTH - s));
			4'd5:  r = a << s;
			4'd6:  r = (a >> s) | (a << (WORD_WIDTH - s));
			4'd7:  r = a >> s;
			4'd8:  r[0] = (a == b);
			4'd9:  r[0] = ($signed(a) < $signed(b));
			4'd10: r[0] = ($signed(a) <= $signed(b));
			4'd11: r[0] = wide[WORD_WIDTH];
			4'd12: begin
				for (int i = 0; i < WORD_WIDTH; i++) begin
					r[i] = a[WORD_WIDTH-1-i];
				end
			end
			4'd13: r = b;
			4'd14: r = {a[7:0], b[7:0]};
			default: r = '0; // Illegal code
		endcase
		return r;
	endfunction

	function automatic memAddr_t addrOf(input idExBundle_t b);
		word_t sum;
		sum = b.readData1 + b.immExt;
		return sum[7:0];
	endfunction

	function automatic retire_t retireRef(input idExBundle_t b, input logic fl);
		idExBundle_t x;
		retire_t     r;
		word_t       opB;
		logic        cond;
		x = b;
		if (fl) begin
			x       = '0; // Bubble
			x.haltN = 1'b1;
		end
		opB = x.ctrl.aluSrc2 ? x.immExt : x.readData2;
		case (x.ctrl.opcode1_0)
			2'd0: cond = (x.readData1 == 16'h0);
			2'd1: cond = (x.readData1 != 16'h0);
			2'd2: cond = x.readData1[WORD_WIDTH-1];
			default: cond = !x.readData1[WORD_WIDTH-1];
		endcase
		r.valid        = 1'b1;
		r.regWrite     = x.ctrl.regWrite;
		r.writeRegSel  = x.writeRegSel;
		r.branchTaken  = x.ctrl.jump | (x.ctrl.pcSrc & cond);
		r.branchTarget = (x.ctrl.pcImm ? x.pcAdd2 : x.readData1) + x.immExt;
		r.haltN        = x.haltN;
		r.err          = x.err | (x.ctrl.aluCtrl == 4'd15);
		if (x.ctrl.memToReg) begin
			r.writeData = shadow[addrOf(x)];
		end else if (x.ctrl.writeDataSel) begin
			r.writeData = x.pcAdd2;
		end else begin
			r.writeData = aluRef(x.ctrl.aluCtrl, x.readData1, opB);
		end
		return r;
	endfunction

	always @(negedge clk) begin
		seenIn    = decodeIn;
		seenFlush = flush;
		seenName  = curName;
		sawStall  = stall;
	end

	always @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			expRet      <= retireRef('0, 1'b1);
			expName     <= "reset bubble";
			expStore    <= 1'b0;
			expStallLen <= 0;
			stallCnt    <= 0;
		end else if (sawStall) begin
			stallCnt <= stallCnt + 1;
		end else begin
			if (expStore) begin
				shadow[expAddr] = expData; // Store commits on its retire edge
			end
			expRet      <= retireRef(seenIn, seenFlush);
			expName     <= seenName;
			expStore    <= !seenFlush && seenIn.ctrl.dMemEn && seenIn.ctrl.dMemWrite;
			expAddr     <= addrOf(seenIn);
			expData     <= seenIn.readData2;
			expStallLen <= (!seenFlush && seenIn.ctrl.dMemEn) ? MEM_LATENCY : 0;
			stallCnt    <= 0;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assert property (@(negedge clk) disable iff (!arstN) !stall |-> (retireOut == expRet))
	else begin
		mismatchErrors++;
		$display("Mismatch %s: expected %h actual %h", expName, expRet, retireOut);
	end

	assert property (@(negedge clk) disable iff (!arstN) !stall |-> (stallCnt == expStallLen))
	else begin
		mismatchErrors++;
		$display("Mismatch %s stall cycles: expected %0d actual %0d",
			expName, expStallLen, stallCnt);
	end

	assert property (@(negedge clk) disable iff (!arstN) stall |-> !retireOut.valid)
	else begin
		otherErrors++;
		$display("Retire record marked valid while the pipeline is stalled");
	end

	assert property (@(negedge clk) !arstN |-> (!stall && !retireOut.regWrite))
	else begin
		otherErrors++;
		$display("Stall or register write is high while reset is held");
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic finishRun();
		$display("Errors: %0d mismatch, %0d other", mismatchErrors, otherErrors);
		if (mismatchErrors == 0 && otherErrors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	endtask

	// Called just after a rising edge, returns on the edge that captures b
	task automatic issue(input idExBundle_t b, input logic fl, input string name);
		int waitCnt;
		waitCnt  = 0;
		decodeIn <= b;
		flush    <= fl;
		curName  <= name;
		@(negedge clk);
		while (stall && waitCnt < 4 * MEM_LATENCY) begin
			waitCnt++;
			@(negedge clk);
		end
		if (stall) begin
			otherErrors++;
			$display("Timeout: stall never dropped while %s waited for capture", name);
			finishRun();
		end else begin
			@(posedge clk);
		end
	endtask

	function automatic idExBundle_t randInstr();
		idExBundle_t b;
		b             = '0;
		b.pcAdd2      = word_t'($urandom);
		b.readData1   = word_t'($urandom);
		b.readData2   = word_t'($urandom);
		b.immExt      = word_t'($urandom);
		b.writeRegSel = regSel_t'($urandom);
		b.haltN       = 1'b1;
		return b;
	endfunction

	initial begin
		void'($urandom(96285));
		arstN          = 1'b0;
		flush          = 1'b0;
		decodeIn       = '0;
		decodeIn.haltN = 1'b1;
		curName        = "idle";
		repeat (8) @(posedge clk);
		arstN <= 1'b1;

		for (int code = 0; code < 15; code++) begin
			for (int src = 0; src < 2; src++) begin
				ins               = randInstr();
				ins.ctrl.aluCtrl  = aluCtrl_t'(code);
				ins.ctrl.aluSrc2  = src[0];
				ins.ctrl.regWrite = 1'b1;
				issue(ins, 1'b0, $sformatf("alu code %0d src %0d", code, src));
			end
		end
		for (int code = 8; code < 11; code++) begin
			ins               = randInstr();
			ins.readData2     = ins.readData1; // Equal operands for the compares
			ins.ctrl.aluCtrl  = aluCtrl_t'(code);
			ins.ctrl.regWrite = 1'b1;
			issue(ins, 1'b0, $sformatf("alu code %0d equal", code));
		end

		for (int pcRel = 0; pcRel < 2; pcRel++) begin
			ins                   = randInstr();
			ins.ctrl.jump         = 1'b1;
			ins.ctrl.pcImm        = pcRel[0];
			ins.ctrl.writeDataSel = 1'b1;
			ins.ctrl.regWrite     = 1'b1;
			issue(ins, 1'b0, $sformatf("jump and link pcImm %0d", pcRel));
			for (int cond = 0; cond < 4; cond++) begin
				for (int kind = 0; kind < 3; kind++) begin
					ins                = randInstr();
					ins.readData1      = (kind == 0) ? 16'h0 :
						(kind == 1) ? (ins.readData1 & 16'h7fff) | 16'h1 : ins.readData1 | 16'h8000;
					ins.ctrl.pcSrc     = 1'b1;
					ins.ctrl.pcImm     = pcRel[0];
					ins.ctrl.opcode1_0 = cond[1:0];
					issue(ins, 1'b0, $sformatf("branch cond %0d kind %0d", cond, kind));
				end
			end
		end

		storeIns                = randInstr();
		storeIns.ctrl.dMemEn    = 1'b1;
		storeIns.ctrl.dMemWrite = 1'b1;
		issue(storeIns, 1'b0, "store");
		ins               = randInstr();
		ins.readData1     = storeIns.readData1;
		ins.immExt        = storeIns.immExt;
		ins.ctrl.dMemEn   = 1'b1;
		ins.ctrl.memToReg = 1'b1;
		ins.ctrl.regWrite = 1'b1;
		ins.haltN         = 1'b0; // Halt held through the stall
		issue(ins, 1'b0, "load after store");
		storeIns.readData2 = ~storeIns.readData2;
		storeIns.err       = 1'b1;
		issue(storeIns, 1'b1, "flushed store");
		ins.haltN = 1'b1;
		issue(ins, 1'b0, "load after flushed store");

		ins              = randInstr();
		ins.ctrl.aluCtrl = 4'd15;
		issue(ins, 1'b0, "illegal alu code");
		ins       = randInstr();
		ins.err   = 1'b1;
		ins.haltN = 1'b0;
		issue(ins, 1'b0, "upstream error with halt");
		issue(ins, 1'b1, "flushed error");

		ins = '0;
		ins.haltN = 1'b1;
		issue(ins, 1'b0, "drain");
		issue(ins, 1'b0, "drain");
		finishRun();
	end

endmodule

/* hw/dataMem.sv */
`timescale 1ns/100ps

module dataMem (
	input  logic              clk,
	input  logic              read,
	input  logic              write,
	input  pipePkg::memAddr_t addr,
	input  pipePkg::word_t    writeData,
	output pipePkg::word_t    readData
);
	import pipePkg::*;

	word_t mem [MEM_WORDS];
	word_t rdWord;

	assign rdWord = mem[addr]; // Async array read

	always_ff @(posedge clk) begin
		if (write) begin
			mem[addr] <= writeData;
		end
	end

	// Held stable through the retire cycle
	always_ff @(posedge clk) begin
		if (read) begin
			readData <= rdWord;
		end
	end

endmodule

/* hw/dmemCtrl.sv */
`timescale 1ns/100ps

module dmemCtrl (
	input  logic                 clk,
	input  logic                 arstN,
	input  pipePkg::idExBundle_t idEx,
	input  logic                 lastCycle,
	output logic                 loadCount,
	output logic                 stall,
	output logic                 memRead,
	output logic                 memWrite
);
	import pipePkg::*;

	memState_t state;
	memState_t nextState;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= IDLE;
		end else begin
			state <= nextState;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Access sequencing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		nextState = state;
		loadCount = 1'b0;
		stall     = 1'b0;
		memRead   = 1'b0;
		memWrite  = 1'b0;
		case (state)
			IDLE: begin
				if (idEx.ctrl.dMemEn) begin
					stall     = 1'b1; // Same cycle as capture
					loadCount = 1'b1;
					nextState = ACCESS;
				end
			end
			ACCESS: begin
				stall = 1'b1;
				if (lastCycle) begin
					memRead   = ~idEx.ctrl.dMemWrite; // Word lands on entry to DONE
					nextState = DONE;
				end
			end
			DONE: begin
				memWrite  = idEx.ctrl.dMemWrite; // Commits on the retire edge
				nextState = IDLE;
			end
			default: nextState = IDLE;
		endcase
	end

endmodule

/* hw/execStage.sv */
`timescale 1ns/100ps

module execStage (
	input  logic                 clk,
	input  logic                 arstN,
	input  logic                 flush,
	input  pipePkg::idExBundle_t decodeIn,
	output logic                 stall,
	output pipePkg::retire_t     retireOut
);
	import pipePkg::*;

	idExBundle_t idEx;
	word_t       aluResult;
	memAddr_t    memAddr;
	logic        branchTaken;
	word_t       branchTarget;
	logic        illegalOp;
	logic        loadCount;
	logic        lastCycle;
	logic        memRead;
	logic        memWrite;
	word_t       memReadData;

	idExReg i_idExReg (
		.clk      (clk),
		.arstN    (arstN),
		.stall    (stall),
		.flush    (flush),
		.decodeIn (decodeIn),
		.idEx     (idEx)
	);

	execUnit i_execUnit (
		.idEx         (idEx),
		.result       (aluResult),
		.memAddr      (memAddr),
		.branchTaken  (branchTaken),
		.branchTarget (branchTarget),
		.illegalOp    (illegalOp)
	);

	dmemCtrl i_dmemCtrl (
		.clk       (clk),
		.arstN     (arstN),
		.idEx      (idEx),
		.lastCycle (lastCycle),
		.loadCount (loadCount),
		.stall     (stall),
		.memRead   (memRead),
		.memWrite  (memWrite)
	);

	waitCounter i_waitCounter (
		.clk       (clk),
		.arstN     (arstN),
		.load      (loadCount),
		.lastCycle (lastCycle)
	);

	dataMem i_dataMem (
		.clk       (clk),
		.read      (memRead),
		.write     (memWrite),
		.addr      (memAddr),
		.writeData (idEx.readData2), // Store data
		.readData  (memReadData)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Retire record
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		retireOut.valid        = ~stall;
		retireOut.regWrite     = idEx.ctrl.regWrite;
		retireOut.writeRegSel  = idEx.writeRegSel;
		retireOut.branchTaken  = branchTaken;
		retireOut.branchTarget = branchTarget;
		retireOut.haltN        = idEx.haltN;
		retireOut.err          = idEx.err | illegalOp;
		if (idEx.ctrl.memToReg) begin
			retireOut.writeData = memReadData;
		end else if (idEx.ctrl.writeDataSel) begin
			retireOut.writeData = idEx.pcAdd2; // Link
		end else begin
			retireOut.writeData = aluResult;
		end
	end

endmodule

/* hw/execUnit.sv */
`timescale 1ns/100ps

module execUnit (
	input  pipePkg::idExBundle_t idEx,
	output pipePkg::word_t       result,
	output pipePkg::memAddr_t    memAddr,
	output logic                 branchTaken,
	output pipePkg::word_t       branchTarget,
	output logic                 illegalOp
);
	import pipePkg::*;

	word_t                   opA;
	word_t                   opB;
	logic [3:0]              shAmt;
	logic [2*WORD_WIDTH-1:0] rotL;
	logic [2*WORD_WIDTH-1:0] rotR;
	logic [WORD_WIDTH:0]     sum;
	word_t                   addrSum;
	word_t                   targetBase;
	logic                    condMet;

	assign opA   = idEx.readData1;
	assign opB   = idEx.ctrl.aluSrc2 ? idEx.immExt : idEx.readData2;
	assign shAmt = opB[3:0];
	assign rotL  = {opA, opA} << shAmt;
	assign rotR  = {opA, opA} >> shAmt;
	assign sum   = {1'b0, opA} + {1'b0, opB}; // Carry kept for code 11

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// ALU
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		illegalOp = 1'b0;
		case (idEx.ctrl.aluCtrl)
			4'd0:  result = sum[WORD_WIDTH-1:0];
			4'd1:  result = opA - opB;
			4'd2:  result = opA ^ opB;
			4'd3:  result = opA & ~opB;
			4'd4:  result = rotL[2*WORD_WIDTH-1:WORD_WIDTH];
			4'd5:  result = opA << shAmt;
			4'd6:  result = rotR[WORD_WIDTH-1:0];
			4'd7:  result = opA >> shAmt;
			4'd8:  result = word_t'(opA == opB);
			4'd9:  result = word_t'($signed(opA) < $signed(opB));
			4'd10: result = word_t'($signed(opA) <= $signed(opB));
			4'd11: result = word_t'(sum[WORD_WIDTH]);
			4'd12: result = {<<{opA}};
			4'd13: result = opB;
			4'd14: result = {opA[7:0], opB[7:0]};
			default: begin
				result    = '0; // Code 15 is not an operation
				illegalOp = 1'b1;
			end
		endcase
	end

	assign addrSum = idEx.readData1 + idEx.immExt;
	assign memAddr = addrSum[$bits(memAddr_t)-1:0]; // Word address

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Branch resolution
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		case (idEx.ctrl.opcode1_0)
			2'd0: condMet = (idEx.readData1 == '0);
			2'd1: condMet = (idEx.readData1 != '0);
			2'd2: condMet = idEx.readData1[WORD_WIDTH-1];
			default: condMet = ~idEx.readData1[WORD_WIDTH-1];
		endcase
	end

	assign branchTaken  = idEx.ctrl.jump | (idEx.ctrl.pcSrc & condMet);
	assign targetBase   = idEx.ctrl.pcImm ? idEx.pcAdd2 : idEx.readData1;
	assign branchTarget = targetBase + idEx.immExt;

endmodule

/* hw/idExReg.sv */
`timescale 1ns/100ps

module idExReg (
	input  logic                 clk,
	input  logic                 arstN,
	input  logic                 stall,
	input  logic                 flush,
	input  pipePkg::idExBundle_t decodeIn,
	output pipePkg::idExBundle_t idEx
);
	import pipePkg::*;

	idExBundle_t nextIdEx;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Next value, bubble on flush
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		nextIdEx = decodeIn;
		if (flush) begin
			nextIdEx       = '0; // No write, no access, no branch
			nextIdEx.haltN = 1'b1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Pipeline register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			idEx       <= '0;
			idEx.haltN <= 1'b1; // Same bubble as flush
		end else if (!stall) begin
			idEx <= nextIdEx;
		end
	end

endmodule

/* hw/pipePkg.sv */
package pipePkg;

	localparam int WORD_WIDTH    = 16;
	localparam int REG_SEL_WIDTH = 3;
	localparam int MEM_WORDS     = 256;
	localparam int MEM_LATENCY   = 3; // Stall cycles per access

	typedef logic [WORD_WIDTH-1:0]             word_t;
	typedef logic [REG_SEL_WIDTH-1:0]          regSel_t;
	typedef logic [3:0]                        aluCtrl_t;
	typedef logic [$clog2(MEM_WORDS)-1:0]      memAddr_t;
	typedef logic [$clog2(MEM_LATENCY)-1:0]    latency_t;

	typedef enum logic [1:0] {
		IDLE,
		ACCESS,
		DONE
	} memState_t;

	// ALU codes
	//   0 add     4 rotl    8 seq      12 bit reverse A
	//   1 sub     5 shl     9 slt      13 pass B
	//   2 xor     6 rotr   10 sle      14 {A[7:0], B[7:0]}
	//   3 andn    7 shr    11 carry    15 illegal
	typedef struct packed {
		logic     aluSrc2;      // 15
		aluCtrl_t aluCtrl;      // 14:11
		logic     pcImm;        // 10
		logic     pcSrc;        // 9
		logic     jump;         // 8
		logic [1:0] opcode1_0;  // 7:6
		logic     dMemEn;       // 5
		logic     dMemWrite;    // 4
		logic     dMemDump;     // 3, spare
		logic     memToReg;     // 2
		logic     writeDataSel; // 1
		logic     regWrite;     // 0
	} idExCtrl_t;

	typedef struct packed {
		idExCtrl_t ctrl;
		word_t     pcAdd2;
		word_t     readData1;
		word_t     readData2;
		word_t     immExt;
		regSel_t   writeRegSel;
		logic      haltN;
		logic      err;
	} idExBundle_t;

	typedef struct packed {
		logic    valid;
		logic    regWrite;
		regSel_t writeRegSel;
		word_t   writeData;
		logic    branchTaken;
		word_t   branchTarget;
		logic    haltN;
		logic    err;
	} retire_t;

endpackage

/* hw/waitCounter.sv */
`timescale 1ns/100ps

module waitCounter (
	input  logic clk,
	input  logic arstN,
	input  logic load,
	output logic lastCycle
);
	import pipePkg::*;

	latency_t count;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			count <= '0;
		end else if (load) begin
			count <= latency_t'(MEM_LATENCY - 1);
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	// High one cycle before zero so the controller leaves ACCESS on time
	assign lastCycle = (count == latency_t'(1));

endmodule

/* run.sh */
#!/bin/sh
# Build and run the execStage testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -j 0 -f verilog.f --top-module execStageTb; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/VexecStageTb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation binary returned status $status"
	exit 1
fi

if echo "$out" | grep -q "^Simulation finished: PASS$"; then
	exit 0
fi
exit 1

/* verilog.f */
hw/pipePkg.sv
hw/idExReg.sv
hw/execUnit.sv
hw/dmemCtrl.sv
hw/waitCounter.sv
hw/dataMem.sv
hw/execStage.sv
dv/execStageTb.sv
